/* Bender.yml */
package:
  name: pr_shell

sources:
  - include_dirs:
      - include
    files:
      - source/pr_shell_pkg.sv
      - source/axi_decoupler.sv
      - source/txn_tracker.sv
      - source/decouple_ctrl.sv
      - source/pr_shell_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/pr_shell_asserts.sv
      - verification/pr_shell_tb.sv

/* include/pr_shell_defines.svh */
// ------------------------------------------------------------------
// region count, AXI bus widths and outstanding-burst limit
// ------------------------------------------------------------------

`ifndef PR_SHELL_DEFINES_SVH
`define PR_SHELL_DEFINES_SVH

// reconfigurable regions behind the shell
`define PR_N_REGIONS 2

// AXI4 bus geometry
`define PR_ADDR_BITS 32
`define PR_DATA_BITS 64
`define PR_ID_BITS 4

// bursts in flight per direction and region
// the counter width follows from this value
`define PR_MAX_OUTSTANDING 15

`endif

/* pr_shell.f */
+incdir+include
source/pr_shell_pkg.sv
source/axi_decoupler.sv
source/txn_tracker.sv
source/decouple_ctrl.sv
source/pr_shell_top.sv
verification/pr_shell_asserts.sv
verification/pr_shell_tb.sv

/* source/axi_decoupler.sv */
// ------------------------------------------------------------------
// per-region handshake gating of the five AXI4 channels
// ------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "pr_shell_defines.svh"

module axi_decoupler import pr_shell_pkg::*; (
  input  logic [`PR_N_REGIONS-1:0]            block_addr,
  input  logic [`PR_N_REGIONS-1:0]            decouple,

  // user side (region logic is master)
  input  axi_addr_t [`PR_N_REGIONS-1:0]       s_araddr,
  input  axi_id_t [`PR_N_REGIONS-1:0]         s_arid,
  input  axi_len_t [`PR_N_REGIONS-1:0]        s_arlen,
  input  logic [`PR_N_REGIONS-1:0][2:0]       s_arsize,
  input  logic [`PR_N_REGIONS-1:0][1:0]       s_arburst,
  input  logic [`PR_N_REGIONS-1:0]            s_arvalid,
  output logic [`PR_N_REGIONS-1:0]            s_arready,
  input  axi_addr_t [`PR_N_REGIONS-1:0]       s_awaddr,
  input  axi_id_t [`PR_N_REGIONS-1:0]         s_awid,
  input  axi_len_t [`PR_N_REGIONS-1:0]        s_awlen,
  input  logic [`PR_N_REGIONS-1:0][2:0]       s_awsize,
  input  logic [`PR_N_REGIONS-1:0][1:0]       s_awburst,
  input  logic [`PR_N_REGIONS-1:0]            s_awvalid,
  output logic [`PR_N_REGIONS-1:0]            s_awready,
  input  axi_data_t [`PR_N_REGIONS-1:0]       s_wdata,
  input  axi_strb_t [`PR_N_REGIONS-1:0]       s_wstrb,
  input  logic [`PR_N_REGIONS-1:0]            s_wlast,
  input  logic [`PR_N_REGIONS-1:0]            s_wvalid,
  output logic [`PR_N_REGIONS-1:0]            s_wready,
  output axi_data_t [`PR_N_REGIONS-1:0]       s_rdata,
  output axi_id_t [`PR_N_REGIONS-1:0]         s_rid,
  output axi_resp_t [`PR_N_REGIONS-1:0]       s_rresp,
  output logic [`PR_N_REGIONS-1:0]            s_rlast,
  output logic [`PR_N_REGIONS-1:0]            s_rvalid,
  input  logic [`PR_N_REGIONS-1:0]            s_rready,
  output axi_id_t [`PR_N_REGIONS-1:0]         s_bid,
  output axi_resp_t [`PR_N_REGIONS-1:0]       s_bresp,
  output logic [`PR_N_REGIONS-1:0]            s_bvalid,
  input  logic [`PR_N_REGIONS-1:0]            s_bready,

  // shell side (shell is slave)
  output axi_addr_t [`PR_N_REGIONS-1:0]       m_araddr,
  output axi_id_t [`PR_N_REGIONS-1:0]         m_arid,
  output axi_len_t [`PR_N_REGIONS-1:0]        m_arlen,
  output logic [`PR_N_REGIONS-1:0][2:0]       m_arsize,
  output logic [`PR_N_REGIONS-1:0][1:0]       m_arburst,
  output logic [`PR_N_REGIONS-1:0]            m_arvalid,
  input  logic [`PR_N_REGIONS-1:0]            m_arready,
  output axi_addr_t [`PR_N_REGIONS-1:0]       m_awaddr,
  output axi_id_t [`PR_N_REGIONS-1:0]         m_awid,
  output axi_len_t [`PR_N_REGIONS-1:0]        m_awlen,
  output logic [`PR_N_REGIONS-1:0][2:0]       m_awsize,
  output logic [`PR_N_REGIONS-1:0][1:0]       m_awburst,
  output logic [`PR_N_REGIONS-1:0]            m_awvalid,
  input  logic [`PR_N_REGIONS-1:0]            m_awready,
  output axi_data_t [`PR_N_REGIONS-1:0]       m_wdata,
  output axi_strb_t [`PR_N_REGIONS-1:0]       m_wstrb,
  output logic [`PR_N_REGIONS-1:0]            m_wlast,
  output logic [`PR_N_REGIONS-1:0]            m_wvalid,
  input  logic [`PR_N_REGIONS-1:0]            m_wready,
  input  axi_data_t [`PR_N_REGIONS-1:0]       m_rdata,
  input  axi_id_t [`PR_N_REGIONS-1:0]         m_rid,
  input  axi_resp_t [`PR_N_REGIONS-1:0]       m_rresp,
  input  logic [`PR_N_REGIONS-1:0]            m_rlast,
  input  logic [`PR_N_REGIONS-1:0]            m_rvalid,
  output logic [`PR_N_REGIONS-1:0]            m_rready,
  input  axi_id_t [`PR_N_REGIONS-1:0]         m_bid,
  input  axi_resp_t [`PR_N_REGIONS-1:0]       m_bresp,
  input  logic [`PR_N_REGIONS-1:0]            m_bvalid,
  output logic [`PR_N_REGIONS-1:0]            m_bready
);

  for (genvar i = 0; i < `PR_N_REGIONS; i++) begin : g_region
    logic addr_cut;

    // address channels close as soon as draining starts
    assign addr_cut = block_addr[i] | decouple[i];

    // ar
    assign m_arvalid[i] = addr_cut ? 1'b0 : s_arvalid[i];
    assign s_arready[i] = addr_cut ? 1'b0 : m_arready[i];
    assign m_araddr[i]  = s_araddr[i];
    assign m_arid[i]    = s_arid[i];
    assign m_arlen[i]   = s_arlen[i];
    assign m_arsize[i]  = s_arsize[i];
    assign m_arburst[i] = s_arburst[i];

    // aw
    assign m_awvalid[i] = addr_cut ? 1'b0 : s_awvalid[i];
    assign s_awready[i] = addr_cut ? 1'b0 : m_awready[i];
    assign m_awaddr[i]  = s_awaddr[i];
    assign m_awid[i]    = s_awid[i];
    assign m_awlen[i]   = s_awlen[i];
    assign m_awsize[i]  = s_awsize[i];
    assign m_awburst[i] = s_awburst[i];

    // w keeps flowing while draining so accepted writes complete
    assign m_wvalid[i] = decouple[i] ? 1'b0 : s_wvalid[i];
    assign s_wready[i] = decouple[i] ? 1'b0 : m_wready[i];
    assign m_wdata[i]  = s_wdata[i];
    assign m_wstrb[i]  = s_wstrb[i];
    assign m_wlast[i]  = s_wlast[i];

    // r
    assign s_rvalid[i] = decouple[i] ? 1'b0 : m_rvalid[i];
    assign m_rready[i] = decouple[i] ? 1'b0 : s_rready[i];
    assign s_rdata[i]  = m_rdata[i];
    assign s_rid[i]    = m_rid[i];
    assign s_rresp[i]  = m_rresp[i];
    assign s_rlast[i]  = m_rlast[i];

    // b
    assign s_bvalid[i] = decouple[i] ? 1'b0 : m_bvalid[i];
    assign m_bready[i] = decouple[i] ? 1'b0 : s_bready[i];
    assign s_bid[i]    = m_bid[i];
    assign s_bresp[i]  = m_bresp[i];
  end

endmodule

`default_nettype wire

/* source/decouple_ctrl.sv */
// ------------------------------------------------------------------
// per-region drain and decouple FSM
// ------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "pr_shell_defines.svh"

module decouple_ctrl import pr_shell_pkg::*; (
  input  logic                                aclk,
  input  logic                                arst_n,

  input  logic [`PR_N_REGIONS-1:0]            decouple_req,
  input  logic [`PR_N_REGIONS-1:0]            pend_idle,

  output logic [`PR_N_REGIONS-1:0]            block_addr,
  output logic [`PR_N_REGIONS-1:0]            decouple,
  output region_state_t [`PR_N_REGIONS-1:0]   region_state
);

  for (genvar i = 0; i < `PR_N_REGIONS; i++) begin : g_region
    region_state_t state_q;
    region_state_t state_d;
    logic          block_q;
    logic          dec_q;

    // ------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------
    always_comb begin
      state_d = state_q;
      case (state_q)
        REGION_ACTIVE: begin
          if (decouple_req[i]) begin
            state_d = REGION_DRAINING;
          end
        end
        REGION_DRAINING: begin
          // dropping the request aborts the drain
          if (!decouple_req[i]) begin
            state_d = REGION_ACTIVE;
          end else if (pend_idle[i]) begin
            state_d = REGION_DECOUPLED;
          end
        end
        REGION_DECOUPLED: begin
          if (!decouple_req[i]) begin
            state_d = REGION_ACTIVE;
          end
        end
        default: begin
          state_d = REGION_ACTIVE;
        end
      endcase
    end

    // ------------------------------------------------------------------
    // state and gate levels, all registered
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
        state_q <= REGION_ACTIVE;
        block_q <= 1'b0;
        dec_q   <= 1'b0;
      end else begin
        state_q <= state_d;
        // addresses stay blocked while draining and decoupled
        block_q <= (state_d != REGION_ACTIVE);
        dec_q   <= (state_d == REGION_DECOUPLED);
      end
    end

    assign block_addr[i]   = block_q;
    assign decouple[i]     = dec_q;
    assign region_state[i] = state_q;
  end

endmodule

`default_nettype wire

/* source/pr_shell_pkg.sv */
// ------------------------------------------------------------------
// AXI field types and region state encoding for the PR shell
// ------------------------------------------------------------------

`default_nettype none

`include "pr_shell_defines.svh"

package pr_shell_pkg;

  // AXI4 payload fields
  typedef logic [`PR_ADDR_BITS-1:0] axi_addr_t;
  typedef logic [`PR_DATA_BITS-1:0] axi_data_t;
  typedef logic [`PR_DATA_BITS/8-1:0] axi_strb_t;
  typedef logic [`PR_ID_BITS-1:0] axi_id_t;
  typedef logic [7:0] axi_len_t;
  typedef logic [1:0] axi_resp_t;

  // outstanding bursts, wide enough for the limit
  typedef logic [$clog2(`PR_MAX_OUTSTANDING+1)-1:0] pend_cnt_t;

  // ------------------------------------------------------------------
  // region life cycle
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    REGION_ACTIVE    = 2'd0,
    REGION_DRAINING  = 2'd1,
    REGION_DECOUPLED = 2'd2
  } region_state_t;

endpackage

`default_nettype wire

/* source/pr_shell_top.sv */
// ------------------------------------------------------------------
// PR isolation shell top with controller, tracker and decoupler
// ------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "pr_shell_defines.svh"

module pr_shell_top import pr_shell_pkg::*; (
  input  logic                                aclk,
  input  logic                                arst_n,

  input  logic [`PR_N_REGIONS-1:0]            decouple_req,
  output region_state_t [`PR_N_REGIONS-1:0]   region_state,

  // user ports, one slot per region
  input  axi_addr_t [`PR_N_REGIONS-1:0]       s_araddr,
  input  axi_id_t [`PR_N_REGIONS-1:0]         s_arid,
  input  axi_len_t [`PR_N_REGIONS-1:0]        s_arlen,
  input  logic [`PR_N_REGIONS-1:0][2:0]       s_arsize,
  input  logic [`PR_N_REGIONS-1:0][1:0]       s_arburst,
  input  logic [`PR_N_REGIONS-1:0]            s_arvalid,
  output logic [`PR_N_REGIONS-1:0]            s_arready,
  input  axi_addr_t [`PR_N_REGIONS-1:0]       s_awaddr,
  input  axi_id_t [`PR_N_REGIONS-1:0]         s_awid,
  input  axi_len_t [`PR_N_REGIONS-1:0]        s_awlen,
  input  logic [`PR_N_REGIONS-1:0][2:0]       s_awsize,
  input  logic [`PR_N_REGIONS-1:0][1:0]       s_awburst,
  input  logic [`PR_N_REGIONS-1:0]            s_awvalid,
  output logic [`PR_N_REGIONS-1:0]            s_awready,
  input  axi_data_t [`PR_N_REGIONS-1:0]       s_wdata,
  input  axi_strb_t [`PR_N_REGIONS-1:0]       s_wstrb,
  input  logic [`PR_N_REGIONS-1:0]            s_wlast,
  input  logic [`PR_N_REGIONS-1:0]            s_wvalid,
  output logic [`PR_N_REGIONS-1:0]            s_wready,
  output axi_data_t [`PR_N_REGIONS-1:0]       s_rdata,
  output axi_id_t [`PR_N_REGIONS-1:0]         s_rid,
  output axi_resp_t [`PR_N_REGIONS-1:0]       s_rresp,
  output logic [`PR_N_REGIONS-1:0]            s_rlast,
  output logic [`PR_N_REGIONS-1:0]            s_rvalid,
  input  logic [`PR_N_REGIONS-1:0]            s_rready,
  output axi_id_t [`PR_N_REGIONS-1:0]         s_bid,
  output axi_resp_t [`PR_N_REGIONS-1:0]       s_bresp,
  output logic [`PR_N_REGIONS-1:0]            s_bvalid,
  input  logic [`PR_N_REGIONS-1:0]            s_bready,

  // shell ports, one slot per region
  output axi_addr_t [`PR_N_REGIONS-1:0]       m_araddr,
  output axi_id_t [`PR_N_REGIONS-1:0]         m_arid,
  output axi_len_t [`PR_N_REGIONS-1:0]        m_arlen,
  output logic [`PR_N_REGIONS-1:0][2:0]       m_arsize,
  output logic [`PR_N_REGIONS-1:0][1:0]       m_arburst,
  output logic [`PR_N_REGIONS-1:0]            m_arvalid,
  input  logic [`PR_N_REGIONS-1:0]            m_arready,
  output axi_addr_t [`PR_N_REGIONS-1:0]       m_awaddr,
  output axi_id_t [`PR_N_REGIONS-1:0]         m_awid,
  output axi_len_t [`PR_N_REGIONS-1:0]        m_awlen,
  output logic [`PR_N_REGIONS-1:0][2:0]       m_awsize,
  output logic [`PR_N_REGIONS-1:0][1:0]       m_awburst,
  output logic [`PR_N_REGIONS-1:0]            m_awvalid,
  input  logic [`PR_N_REGIONS-1:0]            m_awready,
  output axi_data_t [`PR_N_REGIONS-1:0]       m_wdata,
  output axi_strb_t [`PR_N_REGIONS-1:0]       m_wstrb,
  output logic [`PR_N_REGIONS-1:0]            m_wlast,
  output logic [`PR_N_REGIONS-1:0]            m_wvalid,
  input  logic [`PR_N_REGIONS-1:0]            m_wready,
  input  axi_data_t [`PR_N_REGIONS-1:0]       m_rdata,
  input  axi_id_t [`PR_N_REGIONS-1:0]         m_rid,
  input  axi_resp_t [`PR_N_REGIONS-1:0]       m_rresp,
  input  logic [`PR_N_REGIONS-1:0]            m_rlast,
  input  logic [`PR_N_REGIONS-1:0]            m_rvalid,
  output logic [`PR_N_REGIONS-1:0]            m_rready,
  input  axi_id_t [`PR_N_REGIONS-1:0]         m_bid,
  input  axi_resp_t [`PR_N_REGIONS-1:0]       m_bresp,
  input  logic [`PR_N_REGIONS-1:0]            m_bvalid,
  output logic [`PR_N_REGIONS-1:0]            m_bready
);

  logic [`PR_N_REGIONS-1:0] block_addr;
  logic [`PR_N_REGIONS-1:0] decouple;
  logic [`PR_N_REGIONS-1:0] pend_idle;

  decouple_ctrl u_ctrl (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .decouple_req (decouple_req),
    .pend_idle    (pend_idle),
    .block_addr   (block_addr),
    .decouple     (decouple),
    .region_state (region_state)
  );

  // counts what the shell actually accepted, so it taps the gated side
  txn_tracker u_tracker (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .m_arvalid (m_arvalid),
    .m_arready (m_arready),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_rvalid  (m_rvalid),
    .m_rready  (m_rready),
    .m_rlast   (m_rlast),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .pend_idle (pend_idle)
  );

  // bus ports share their names with the top ports
  axi_decoupler u_decoupler (.*);

endmodule

`default_nettype wire

/* source/txn_tracker.sv */
// ------------------------------------------------------------------
// outstanding read and write burst counters per region
// ------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "pr_shell_defines.svh"

module txn_tracker import pr_shell_pkg::*; (
  input  logic                        aclk,
  input  logic                        arst_n,

  // shell-side handshakes, after gating
  input  logic [`PR_N_REGIONS-1:0]    m_arvalid,
  input  logic [`PR_N_REGIONS-1:0]    m_arready,
  input  logic [`PR_N_REGIONS-1:0]    m_awvalid,
  input  logic [`PR_N_REGIONS-1:0]    m_awready,
  input  logic [`PR_N_REGIONS-1:0]    m_rvalid,
  input  logic [`PR_N_REGIONS-1:0]    m_rready,
  input  logic [`PR_N_REGIONS-1:0]    m_rlast,
  input  logic [`PR_N_REGIONS-1:0]    m_bvalid,
  input  logic [`PR_N_REGIONS-1:0]    m_bready,

  output logic [`PR_N_REGIONS-1:0]    pend_idle
);

  pend_cnt_t rd_cnt [`PR_N_REGIONS];
  pend_cnt_t wr_cnt [`PR_N_REGIONS];

  for (genvar i = 0; i < `PR_N_REGIONS; i++) begin : g_region
    logic ar_hs;
    logic r_done;
    logic aw_hs;
    logic b_hs;

    assign ar_hs  = m_arvalid[i] & m_arready[i];
    // a read burst ends with its last beat
    assign r_done = m_rvalid[i] & m_rready[i] & m_rlast[i];
    assign aw_hs  = m_awvalid[i] & m_awready[i];
    assign b_hs   = m_bvalid[i] & m_bready[i];

    // ------------------------------------------------------------------
    // read bursts
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
        rd_cnt[i] <= '0;
      end else if (ar_hs && !r_done) begin
        rd_cnt[i] <= rd_cnt[i] + 1'b1;
      end else if (!ar_hs && r_done) begin
        rd_cnt[i] <= rd_cnt[i] - 1'b1;
      end
    end

    // ------------------------------------------------------------------
    // write bursts, closed by the B response
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
        wr_cnt[i] <= '0;
      end else if (aw_hs && !b_hs) begin
        wr_cnt[i] <= wr_cnt[i] + 1'b1;
      end else if (!aw_hs && b_hs) begin
        wr_cnt[i] <= wr_cnt[i] - 1'b1;
      end
    end

    assign pend_idle[i] = (rd_cnt[i] == '0) && (wr_cnt[i] == '0);
  end

endmodule

`default_nettype wire

/* verification/pr_shell_asserts.sv */
// ------------------------------------------------------------------
// bound checks on gating levels, burst counters and reset state
// ------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "pr_shell_defines.svh"

module pr_shell_asserts import pr_shell_pkg::*; (
  input logic                              aclk,
  input logic                              arst_n,
  input region_state_t [`PR_N_REGIONS-1:0] region_state,
  input logic [`PR_N_REGIONS-1:0]          block_addr,
  input logic [`PR_N_REGIONS-1:0]          m_arvalid, m_awvalid, m_wvalid,
  input logic [`PR_N_REGIONS-1:0]          s_arready, s_awready, s_wready,
  input pend_cnt_t                         rd_cnt [`PR_N_REGIONS],
  input pend_cnt_t                         wr_cnt [`PR_N_REGIONS]
);

  // number of failed assertions
  int failures = 0;

  for (genvar i = 0; i < `PR_N_REGIONS; i++) begin : g_region
    // decoupled region is silent towards the shell and the user
    assert property (@(posedge aclk) disable iff (!arst_n)
      region_state[i] == REGION_DECOUPLED |-> !(m_arvalid[i] | m_awvalid[i] | m_wvalid[i]
        | s_arready[i] | s_awready[i] | s_wready[i]))
    else begin
      failures++;
      $error("region %0d has a live handshake while decoupled", i);
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
      block_addr[i] |-> !m_arvalid[i] && !m_awvalid[i])
    else begin
      failures++;
      $error("region %0d passes an address while blocked", i);
    end

    // at the limit a counter may only hold or count down
    assert property (@(posedge aclk) disable iff (!arst_n)
      rd_cnt[i] == `PR_MAX_OUTSTANDING |=>
        rd_cnt[i] inside {`PR_MAX_OUTSTANDING, `PR_MAX_OUTSTANDING - 1})
    else begin
      failures++;
      $error("region %0d read counter moved past its limit", i);
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
      wr_cnt[i] == `PR_MAX_OUTSTANDING |=>
        wr_cnt[i] inside {`PR_MAX_OUTSTANDING, `PR_MAX_OUTSTANDING - 1})
    else begin
      failures++;
      $error("region %0d write counter moved past its limit", i);
    end

    assert property (@(posedge aclk) $rose(arst_n) |-> region_state[i] == REGION_ACTIVE)
    else begin
      failures++;
      $error("region %0d not active after reset release", i);
    end
  end

endmodule

`default_nettype wire

/* verification/pr_shell_tb.sv */
// ------------------------------------------------------------------
// directed tests for the PR shell, acting as user master on the s
// ports and as shell slave on the m ports
// ------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "pr_shell_defines.svh"

module pr_shell_tb import pr_shell_pkg::*; ();

  // a full run takes a few hundred cycles
  localparam int CYCLE_LIMIT = 2000;

  logic aclk;
  logic arst_n;
  logic [`PR_N_REGIONS-1:0] decouple_req;
  region_state_t [`PR_N_REGIONS-1:0] region_state;
  axi_addr_t [`PR_N_REGIONS-1:0] s_araddr, s_awaddr, m_araddr, m_awaddr;
  axi_id_t [`PR_N_REGIONS-1:0] s_arid, s_awid, s_rid, s_bid, m_arid, m_awid, m_rid, m_bid;
  axi_len_t [`PR_N_REGIONS-1:0] s_arlen, s_awlen, m_arlen, m_awlen;
  logic [`PR_N_REGIONS-1:0][2:0] s_arsize, s_awsize, m_arsize, m_awsize;
  logic [`PR_N_REGIONS-1:0][1:0] s_arburst, s_awburst, m_arburst, m_awburst;
  axi_data_t [`PR_N_REGIONS-1:0] s_wdata, m_wdata, s_rdata, m_rdata;
  axi_strb_t [`PR_N_REGIONS-1:0] s_wstrb, m_wstrb;
  axi_resp_t [`PR_N_REGIONS-1:0] s_rresp, s_bresp, m_rresp, m_bresp;
  logic [`PR_N_REGIONS-1:0] s_arvalid, s_arready, s_awvalid, s_awready, s_wvalid, s_wready;
  logic [`PR_N_REGIONS-1:0] s_wlast, s_rlast, s_rvalid, s_rready, s_bvalid, s_bready;
  logic [`PR_N_REGIONS-1:0] m_arvalid, m_arready, m_awvalid, m_awready, m_wvalid, m_wready;
  logic [`PR_N_REGIONS-1:0] m_wlast, m_rlast, m_rvalid, m_rready, m_bvalid, m_bready;

  integer seed;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;

  pr_shell_top uut (.*);

  // the burst counters live inside the tracker
  bind pr_shell_top pr_shell_asserts u_asserts (
    .*,
    .rd_cnt (u_tracker.rd_cnt),
    .wr_cnt (u_tracker.wr_cnt)
  );

  initial aclk = 1'b0;
  always #5 aclk = ~aclk;

  always @(posedge aclk) begin
    cycles <= cycles + 1;
  end

  initial begin
    wait (cycles == CYCLE_LIMIT);
    $display("timeout, run stopped after %0d cycles", CYCLE_LIMIT);
    $display("tests failed");
    $finish;
  end

  // ------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------
  task automatic report_mismatch(input string name, input string got, input string exp);
    $display("mismatch at %0t ns: %s is %s, expected %s", $time, name, got, exp);
    errors++;
  endtask

  task automatic check_addr(input string name, input axi_addr_t got, exp);
    if (got !== exp)
      report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic check_data(input string name, input axi_data_t got, exp);
    if (got !== exp)
      report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic check_strb(input string name, input axi_strb_t got, exp);
    if (got !== exp)
      report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic check_id(input string name, input axi_id_t got, exp);
    if (got !== exp)
      report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic check_len(input string name, input axi_len_t got, exp);
    if (got !== exp)
      report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
  endtask

  task automatic check_size(input string name, input logic [2:0] got, exp);
    if (got !== exp)
      report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic check_burst(input string name, input logic [1:0] got, exp);
    if (got !== exp)
      report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic check_resp(input string name, input axi_resp_t got, exp);
    if (got !== exp)
      report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp)
      report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic check_state(input string name, input region_state_t got, exp);
    if (got !== exp)
      report_mismatch(name, got.name(), exp.name());
  endtask

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("test %-14s FAILED, %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic idle_handshakes();
    @(negedge aclk);
    {s_arvalid, s_awvalid, s_wvalid, s_rready, s_bready} = '0;
    {m_arready, m_awready, m_wready, m_rvalid, m_bvalid} = '0;
  endtask

  task automatic wait_state(input int r, input region_state_t exp, input int n);
    int k;
    k = 0;
    while (region_state[r] !== exp && k < n) begin
      @(negedge aclk);
      k++;
    end
    if (region_state[r] !== exp) begin
      $display("region %0d did not reach %s within %0d cycles", r, exp.name(), n);
      errors++;
    end
  endtask

  task automatic reactivate(input int r);
    @(negedge aclk);
    decouple_req[r] = 1'b0;
    wait_state(r, REGION_ACTIVE, 3);
  endtask

  // valid and ready never meet, so no burst is opened
  task automatic random_traffic(input int r);
    logic v;
    repeat (6) begin
      @(negedge aclk);
      v = $random(seed);
      s_araddr[r] = $random(seed);
      s_arid[r] = $random(seed);
      s_arlen[r] = $random(seed);
      s_arsize[r] = $random(seed);
      s_arburst[r] = $random(seed);
      s_awaddr[r] = $random(seed);
      s_awid[r] = $random(seed);
      s_awlen[r] = $random(seed);
      s_awsize[r] = $random(seed);
      s_awburst[r] = $random(seed);
      s_wdata[r] = {$random(seed), $random(seed)};
      s_wstrb[r] = $random(seed);
      m_rdata[r] = {$random(seed), $random(seed)};
      m_rid[r] = $random(seed);
      m_rresp[r] = $random(seed);
      m_bresp[r] = $random(seed);
      s_arvalid[r] = v;
      m_arready[r] = !v;
      s_awvalid[r] = !v;
      m_awready[r] = v;
      s_wvalid[r] = v;
      m_wready[r] = !v;
      m_rvalid[r] = !v;
      s_rready[r] = v;
      m_bvalid[r] = v;
      s_bready[r] = !v;
      #2;
      check_addr("m_araddr", m_araddr[r], s_araddr[r]);
      check_id("m_arid", m_arid[r], s_arid[r]);
      check_len("m_arlen", m_arlen[r], s_arlen[r]);
      check_size("m_arsize", m_arsize[r], s_arsize[r]);
      check_burst("m_arburst", m_arburst[r], s_arburst[r]);
      check_addr("m_awaddr", m_awaddr[r], s_awaddr[r]);
      check_id("m_awid", m_awid[r], s_awid[r]);
      check_len("m_awlen", m_awlen[r], s_awlen[r]);
      check_size("m_awsize", m_awsize[r], s_awsize[r]);
      check_burst("m_awburst", m_awburst[r], s_awburst[r]);
      check_data("m_wdata", m_wdata[r], s_wdata[r]);
      check_strb("m_wstrb", m_wstrb[r], s_wstrb[r]);
      check_data("s_rdata", s_rdata[r], m_rdata[r]);
      check_id("s_rid", s_rid[r], m_rid[r]);
      check_resp("s_rresp", s_rresp[r], m_rresp[r]);
      check_resp("s_bresp", s_bresp[r], m_bresp[r]);
      check_bit("m_arvalid", m_arvalid[r], v);
      check_bit("s_arready", s_arready[r], !v);
      check_bit("m_awvalid", m_awvalid[r], !v);
      check_bit("s_awready", s_awready[r], v);
      check_bit("m_wvalid", m_wvalid[r], v);
      check_bit("s_wready", s_wready[r], !v);
      check_bit("s_rvalid", s_rvalid[r], !v);
      check_bit("m_rready", m_rready[r], v);
      check_bit("s_bvalid", s_bvalid[r], v);
      check_bit("m_bready", m_bready[r], !v);
    end
    idle_handshakes();
  endtask

  // ------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------
  task automatic pass_through();
    int e;
    e = errors;
    for (int r = 0; r < `PR_N_REGIONS; r++) begin
      random_traffic(r);
    end
    finish_test("pass_through", e);
  endtask

  task automatic idle_decouple();
    int e;
    e = errors;
    @(negedge aclk);
    decouple_req[0] = 1'b1;
    {s_arvalid[0], s_awvalid[0], s_wvalid[0], m_rvalid[0], m_bvalid[0]} = '1;
    wait_state(0, REGION_DECOUPLED, 4);
    #2;
    check_bit("m_arvalid", m_arvalid[0], 1'b0);
    check_bit("m_awvalid", m_awvalid[0], 1'b0);
    check_bit("m_wvalid", m_wvalid[0], 1'b0);
    check_bit("s_rvalid", s_rvalid[0], 1'b0);
    check_bit("s_bvalid", s_bvalid[0], 1'b0);
    idle_handshakes();
    finish_test("idle_decouple", e);
  endtask

  task automatic read_drain();
    int e;
    e = errors;
    @(negedge aclk);
    s_araddr[0] = $random(seed);
    s_arlen[0] = 8'd3;
    s_arvalid[0] = 1'b1;
    m_arready[0] = 1'b1;
    @(negedge aclk);
    {s_arvalid[0], m_arready[0]} = '0;
    decouple_req[0] = 1'b1;
    wait_state(0, REGION_DRAINING, 2);
    // a second address must stay on the user side
    {s_arvalid[0], m_arready[0]} = '1;
    for (int b = 0; b < 4; b++) begin
      @(negedge aclk);
      m_rdata[0] = {$random(seed), $random(seed)};
      m_rlast[0] = (b == 3);
      m_rvalid[0] = 1'b1;
      s_rready[0] = 1'b1;
      #2;
      check_state("region_state", region_state[0], REGION_DRAINING);
      check_bit("m_arvalid", m_arvalid[0], 1'b0);
      check_bit("s_rvalid", s_rvalid[0], 1'b1);
      check_bit("s_rlast", s_rlast[0], b == 3);
      check_data("s_rdata", s_rdata[0], m_rdata[0]);
    end
    @(negedge aclk);
    {m_rvalid[0], m_rlast[0]} = '0;
    check_state("region_state", region_state[0], REGION_DRAINING);
    wait_state(0, REGION_DECOUPLED, 2);
    idle_handshakes();
    finish_test("read_drain", e);
  endtask

  task automatic write_drain();
    int e;
    e = errors;
    @(negedge aclk);
    s_awaddr[0] = $random(seed);
    s_awid[0] = 4'h5;
    s_awlen[0] = 8'd1;
    {s_awvalid[0], m_awready[0]} = '1;
    @(negedge aclk);
    {s_awvalid[0], m_awready[0]} = '0;
    decouple_req[0] = 1'b1;
    wait_state(0, REGION_DRAINING, 2);
    for (int b = 0; b < 2; b++) begin
      @(negedge aclk);
      s_wdata[0] = {$random(seed), $random(seed)};
      s_wlast[0] = (b == 1);
      {s_wvalid[0], m_wready[0]} = '1;
      #2;
      check_bit("m_wvalid", m_wvalid[0], 1'b1);
      check_bit("m_wlast", m_wlast[0], b == 1);
      check_data("m_wdata", m_wdata[0], s_wdata[0]);
    end
    @(negedge aclk);
    {s_wvalid[0], m_wready[0], s_wlast[0]} = '0;
    // shell holds the response back for a while
    repeat (3) begin
      @(negedge aclk);
      check_state("region_state", region_state[0], REGION_DRAINING);
    end
    m_bid[0] = 4'h5;
    m_bresp[0] = 2'b00;
    {m_bvalid[0], s_bready[0]} = '1;
    #2;
    check_bit("s_bvalid", s_bvalid[0], 1'b1);
    check_id("s_bid", s_bid[0], 4'h5);
    check_resp("s_bresp", s_bresp[0], 2'b00);
    @(negedge aclk);
    {m_bvalid[0], s_bready[0]} = '0;
    check_state("region_state", region_state[0], REGION_DRAINING);
    wait_state(0, REGION_DECOUPLED, 2);
    finish_test("write_drain", e);
  endtask

  task automatic independence();
    int e;
    e = errors;
    random_traffic(1);
    check_state("region_state", region_state[0], REGION_DECOUPLED);
    check_state("region_state", region_state[1], REGION_ACTIVE);
    finish_test("independence", e);
  endtask

  task automatic release_traffic();
    int e;
    e = errors;
    reactivate(0);
    check_state("region_state", region_state[0], REGION_ACTIVE);
    random_traffic(0);
    finish_test("release", e);
  endtask

  initial begin
    seed = 32'h9d46_ce0e;
    arst_n = 1'b0;
    decouple_req = '0;
    {s_araddr, s_arid, s_arlen, s_arsize, s_arburst, s_arvalid} = '0;
    {s_awaddr, s_awid, s_awlen, s_awsize, s_awburst, s_awvalid} = '0;
    {s_wdata, s_wstrb, s_wlast, s_wvalid, s_rready, s_bready} = '0;
    {m_arready, m_awready, m_wready, m_bid, m_bresp, m_bvalid} = '0;
    {m_rdata, m_rid, m_rresp, m_rlast, m_rvalid} = '0;
    repeat (10) @(negedge aclk);
    arst_n = 1'b1;
    pass_through();
    idle_decouple();
    reactivate(0);
    read_drain();
    reactivate(0);
    write_drain();
    independence();
    release_traffic();
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion errors",
             tests_run, tests_failed, errors, uut.u_asserts.failures);
    if (errors == 0 && uut.u_asserts.failures == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
